// ==== include/ooo_settings.svh ====
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// datapath word width
`define OOO_XLEN 32

// result tag width, one rob index
`define OOO_TAG_W 5

// entries in each reservation station
`define OOO_RS_DEPTH 4

// multiplier pipeline depth
`define OOO_MUL_STAGES 3

`endif

// ==== logic/issue_types_pkg.sv ====
`default_nettype none

`include "ooo_settings.svh"

package issue_types_pkg;

    // producer / destination tag
    typedef logic [`OOO_TAG_W-1:0] tag_t;

    // alu operations, values 6 and 7 unused
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5
    } alu_op_t;

    // multiplier operations
    typedef enum logic [2:0] {
        mul_lo  = 3'd0,
        mul_hi  = 3'd1,
        mul_hsu = 3'd2
    } mul_op_t;

    // same op word, alu station reads .alu and mul station reads .mul
    typedef union packed {
        alu_op_t alu;
        mul_op_t mul;
    } op_u;

    // source operand, either ready data or the tag it waits on
    typedef struct packed {
        logic                 ready;
        tag_t                 tag;
        logic [`OOO_XLEN-1:0] data;
    } src_operand_t;

    // dispatch word and station slot
    typedef struct packed {
        logic         valid;
        op_u          op;
        tag_t         dest;
        src_operand_t src1;
        src_operand_t src2;
    } rs_entry_t;

    // station to unit
    typedef struct packed {
        op_u                  op;
        tag_t                 dest;
        logic [`OOO_XLEN-1:0] src1;
        logic [`OOO_XLEN-1:0] src2;
    } issue_t;

endpackage

`default_nettype wire

// ==== logic/cdb_pkg.sv ====
`default_nettype none

`include "ooo_settings.svh"

package cdb_pkg;

    import issue_types_pkg::*;

    // one peer asking for the bus, held until granted
    typedef struct packed {
        logic                 valid;
        tag_t                 tag;
        logic [`OOO_XLEN-1:0] data;
    } cdb_req_t;

    // registered broadcast
    typedef struct packed {
        logic                 valid;
        tag_t                 tag;
        logic [`OOO_XLEN-1:0] data;
    } cdb_t;

endpackage

`default_nettype wire

// ==== logic/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module reservation_station #(
    parameter int DEPTH = `OOO_RS_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  issue_types_pkg::rs_entry_t dispatch,
    input  cdb_pkg::cdb_t              cdb,
    input  logic                       flush,
    input  logic                       unit_busy,
    output issue_types_pkg::issue_t    issue,
    output logic                       issue_valid,
    output logic                       rs_available
);
    import issue_types_pkg::*;
    import cdb_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // age = number of younger valid entries, never above DEPTH-1
    localparam int AGE_W = IDX_W;

    logic [DEPTH-1:0] slot_valid;
    rs_entry_t        slots [DEPTH];
    logic [AGE_W-1:0] age [DEPTH];

    logic             accept;
    logic [IDX_W-1:0] free_idx;
    logic             any_free;
    logic [IDX_W-1:0] sel_idx;
    logic [AGE_W-1:0] sel_age;
    logic             sel_found;
    rs_entry_t        dispatch_woken;

    // capture a matching broadcast into a waiting operand
    function automatic src_operand_t wake(input src_operand_t src, input cdb_t bus);
        src_operand_t woken;
        woken = src;
        if (bus.valid && !src.ready && (bus.tag == src.tag)) begin
            woken.ready = 1'b1;
            woken.data  = bus.data;
        end
        return woken;
    endfunction

    // incoming entry sees the same broadcast as the stored ones
    always_comb begin
        dispatch_woken      = dispatch;
        dispatch_woken.src1 = wake(dispatch.src1, cdb);
        dispatch_woken.src2 = wake(dispatch.src2, cdb);
    end

    always_comb begin
        free_idx  = '0;
        any_free  = 1'b0;
        sel_idx   = '0;
        sel_age   = '0;
        sel_found = 1'b0;
        // walk down so the lowest free slot wins
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_idx = IDX_W'(i);
                any_free = 1'b1;
            end
        end
        // oldest ready, strict compare keeps the lower slot on a tie
        for (int i = 0; i < DEPTH; i++) begin
            if (slot_valid[i] && slots[i].src1.ready && slots[i].src2.ready &&
                (!sel_found || (age[i] > sel_age))) begin
                sel_idx   = IDX_W'(i);
                sel_age   = age[i];
                sel_found = 1'b1;
            end
        end
    end

    assign rs_available = any_free;
    assign accept       = dispatch.valid && any_free;
    assign issue_valid  = sel_found && !unit_busy && !flush;

    assign issue.op   = slots[sel_idx].op;
    assign issue.dest = slots[sel_idx].dest;
    assign issue.src1 = slots[sel_idx].src1.data;
    assign issue.src2 = slots[sel_idx].src2.data;

    // slot occupancy and relative age
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                age[i] <= '0;
            end
        end else if (flush) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (accept && (free_idx == IDX_W'(i))) begin
                    slot_valid[i] <= 1'b1;
                    age[i]        <= '0;
                end else begin
                    // freed on issue, not on broadcast
                    if (issue_valid && (sel_idx == IDX_W'(i))) begin
                        slot_valid[i] <= 1'b0;
                    end
                    // one more younger on accept, one fewer if a younger one leaves
                    age[i] <= age[i] + AGE_W'(accept)
                            - AGE_W'(issue_valid && (age[i] > sel_age));
                end
            end
        end
    end

    // payload and operand wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (accept && (free_idx == IDX_W'(i))) begin
                slots[i] <= dispatch_woken;
            end else begin
                slots[i].src1 <= wake(slots[i].src1, cdb);
                slots[i].src2 <= wake(slots[i].src2, cdb);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module alu_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  issue_types_pkg::issue_t issue,
    input  logic                    issue_valid,
    input  logic                    flush,
    input  logic                    grant,
    output logic                    busy,
    output cdb_pkg::cdb_req_t       req
);
    import issue_types_pkg::*;

    logic [`OOO_XLEN-1:0] alu_result;
    logic                 res_valid;
    tag_t                 res_tag;
    logic [`OOO_XLEN-1:0] res_data;

    // alu view of the op word
    always_comb begin
        case (issue.op.alu)
            alu_add: alu_result = issue.src1 + issue.src2;
            alu_sub: alu_result = issue.src1 - issue.src2;
            alu_and: alu_result = issue.src1 & issue.src2;
            alu_or:  alu_result = issue.src1 | issue.src2;
            alu_xor: alu_result = issue.src1 ^ issue.src2;
            // signed compare
            alu_slt: alu_result = `OOO_XLEN'($signed(issue.src1) < $signed(issue.src2));
            default: alu_result = '0;
        endcase
    end

    // result waits here until the bus takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (flush) begin
            res_valid <= 1'b0;
        end else if (issue_valid) begin
            res_valid <= 1'b1;
        end else if (grant) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res_tag  <= issue.dest;
            res_data <= alu_result;
        end
    end

    // free again in the grant cycle, so back to back issue works
    assign busy = res_valid && !grant;
    assign req  = '{valid: res_valid, tag: res_tag, data: res_data};

endmodule

`default_nettype wire

// ==== logic/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module mul_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  issue_types_pkg::issue_t issue,
    input  logic                    issue_valid,
    input  logic                    flush,
    input  logic                    grant,
    output logic                    busy,
    output cdb_pkg::cdb_req_t       req
);
    import issue_types_pkg::*;

    localparam int XLEN   = `OOO_XLEN;
    localparam int STAGES = `OOO_MUL_STAGES;

    logic [STAGES-1:0]  stage_valid;
    tag_t               stage_tag  [STAGES];
    mul_op_t            stage_op   [STAGES];
    logic [2*XLEN-1:0]  stage_prod [STAGES];

    logic               advance;
    logic [XLEN:0]      a_ext;
    logic [XLEN:0]      b_ext;
    logic [2*XLEN+1:0]  full_prod;

    // one extra bit so hsu can treat src2 as unsigned
    assign a_ext     = {issue.src1[XLEN-1], issue.src1};
    assign b_ext     = (issue.op.mul == mul_hsu) ? {1'b0, issue.src2}
                                                 : {issue.src2[XLEN-1], issue.src2};
    assign full_prod = $signed(a_ext) * $signed(b_ext);

    // whole pipe moves together, stalled by an ungranted tail
    assign advance = !stage_valid[STAGES-1] || grant;
    assign busy    = !advance;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (flush) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[STAGES-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            // full product formed in the first stage
            stage_tag[0]  <= issue.dest;
            stage_op[0]   <= issue.op.mul;
            stage_prod[0] <= full_prod[2*XLEN-1:0];
            for (int i = 1; i < STAGES; i++) begin
                stage_tag[i]  <= stage_tag[i-1];
                stage_op[i]   <= stage_op[i-1];
                stage_prod[i] <= stage_prod[i-1];
            end
        end
    end

    // low half for mul_lo, high half otherwise
    assign req.valid = stage_valid[STAGES-1];
    assign req.tag   = stage_tag[STAGES-1];
    assign req.data  = (stage_op[STAGES-1] == mul_lo) ? stage_prod[STAGES-1][XLEN-1:0]
                                                      : stage_prod[STAGES-1][2*XLEN-1:XLEN];

endmodule

`default_nettype wire

// ==== logic/cdb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  cdb_pkg::cdb_req_t mul_req,
    input  cdb_pkg::cdb_req_t alu_req,
    input  cdb_pkg::cdb_req_t ext_req,
    input  logic              flush,
    output logic              mul_grant,
    output logic              alu_grant,
    output logic              ext_grant,
    output cdb_pkg::cdb_t     cdb
);
    import issue_types_pkg::*;
    import cdb_pkg::*;

    cdb_req_t             winner;
    logic                 bcast_valid;
    tag_t                 bcast_tag;
    logic [$bits(winner.data)-1:0] bcast_data;

    // fixed priority mul > alu > ext, nothing granted while flushing
    always_comb begin
        mul_grant = 1'b0;
        alu_grant = 1'b0;
        ext_grant = 1'b0;
        if (!flush) begin
            if (mul_req.valid) begin
                mul_grant = 1'b1;
            end else if (alu_req.valid) begin
                alu_grant = 1'b1;
            end else if (ext_req.valid) begin
                ext_grant = 1'b1;
            end
        end
    end

    assign winner = mul_grant ? mul_req : (alu_grant ? alu_req : ext_req);

    // broadcast one cycle after the grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bcast_valid <= 1'b0;
        end else begin
            bcast_valid <= mul_grant || alu_grant || ext_grant;
        end
    end

    always_ff @(posedge clk) begin
        bcast_tag  <= winner.tag;
        bcast_data <= winner.data;
    end

    assign cdb = '{valid: bcast_valid, tag: bcast_tag, data: bcast_data};

endmodule

`default_nettype wire

// ==== logic/issue_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module issue_cluster (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  issue_types_pkg::rs_entry_t alu_dispatch,
    input  issue_types_pkg::rs_entry_t mul_dispatch,
    input  cdb_pkg::cdb_req_t          ext_req,
    output logic                       ext_grant,
    output logic                       alu_rs_available,
    output logic                       mul_rs_available,
    output cdb_pkg::cdb_t              cdb
);
    import issue_types_pkg::*;
    import cdb_pkg::*;

    // station to unit
    issue_t   alu_issue;
    issue_t   mul_issue;
    logic     alu_issue_valid;
    logic     mul_issue_valid;
    logic     alu_busy;
    logic     mul_busy;

    // unit to arbiter
    cdb_req_t alu_req;
    cdb_req_t mul_req;
    logic     alu_grant;
    logic     mul_grant;

    reservation_station #(
        .DEPTH (`OOO_RS_DEPTH)
    ) alu_rs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch     (alu_dispatch),
        .cdb          (cdb),
        .flush        (flush),
        .unit_busy    (alu_busy),
        .issue        (alu_issue),
        .issue_valid  (alu_issue_valid),
        .rs_available (alu_rs_available)
    );

    reservation_station #(
        .DEPTH (`OOO_RS_DEPTH)
    ) mul_rs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch     (mul_dispatch),
        .cdb          (cdb),
        .flush        (flush),
        .unit_busy    (mul_busy),
        .issue        (mul_issue),
        .issue_valid  (mul_issue_valid),
        .rs_available (mul_rs_available)
    );

    alu_unit alu_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (alu_issue),
        .issue_valid (alu_issue_valid),
        .flush       (flush),
        .grant       (alu_grant),
        .busy        (alu_busy),
        .req         (alu_req)
    );

    mul_unit mul_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (mul_issue),
        .issue_valid (mul_issue_valid),
        .flush       (flush),
        .grant       (mul_grant),
        .busy        (mul_busy),
        .req         (mul_req)
    );

    // one bus shared by both units and the load return
    cdb_arbiter cdb_arbiter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_req   (mul_req),
        .alu_req   (alu_req),
        .ext_req   (ext_req),
        .flush     (flush),
        .mul_grant (mul_grant),
        .alu_grant (alu_grant),
        .ext_grant (ext_grant),
        .cdb       (cdb)
    );

endmodule

`default_nettype wire

// ==== verification/issue_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module issue_cluster_tb;
    import issue_types_pkg::*;
    import cdb_pkg::*;

    localparam int NUM_TAGS   = 1 << `OOO_TAG_W;
    localparam int MAX_VECS   = 64;
    localparam int WAIT_LIMIT = 200;

    // command codes of the vector file
    localparam logic [3:0] CMD_END   = 4'h0;
    localparam logic [3:0] CMD_ALU   = 4'h1;
    localparam logic [3:0] CMD_MUL   = 4'h2;
    localparam logic [3:0] CMD_LOAD  = 4'h3;
    localparam logic [3:0] CMD_FLUSH = 4'h4;
    localparam logic [3:0] CMD_DRAIN = 4'h5;
    localparam logic [3:0] CMD_AVAIL = 4'h6;
    localparam logic [3:0] CMD_IDLE  = 4'h7;

    // one line of the vector file in hex digit fields
    typedef struct packed {
        logic [3:0]  test;
        logic [3:0]  cmd;
        logic [3:0]  op;
        logic [7:0]  dest;
        logic [3:0]  ready1;
        logic [7:0]  tag1;
        logic [31:0] data1;
        logic [3:0]  ready2;
        logic [7:0]  tag2;
        logic [31:0] data2;
        logic [31:0] expected;
    } vector_t;

    typedef enum {tag_idle, tag_pending, tag_done, tag_killed} tag_state_t;

    logic      clk;
    logic      rst_n;
    logic      flush;
    rs_entry_t alu_dispatch;
    rs_entry_t mul_dispatch;
    cdb_req_t  ext_req;
    logic      ext_grant;
    logic      alu_rs_available;
    logic      mul_rs_available;
    cdb_t      cdb;

    logic [$bits(vector_t)-1:0] vector_mem [MAX_VECS];

    // scoreboard indexed by tag
    logic [`OOO_XLEN-1:0] exp_data  [NUM_TAGS];
    tag_state_t           tag_state [NUM_TAGS];
    logic [3:0]           tag_test  [NUM_TAGS];
    int                   pending_count;

    int   value_errors;
    int   protocol_errors;
    int   timeouts;
    logic timed_out;

    issue_cluster issue_cluster_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .alu_dispatch     (alu_dispatch),
        .mul_dispatch     (mul_dispatch),
        .ext_req          (ext_req),
        .ext_grant        (ext_grant),
        .alu_rs_available (alu_rs_available),
        .mul_rs_available (mul_rs_available),
        .cdb              (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "independent";
            4'd2:    return "dependency";
            4'd3:    return "bypass";
            4'd4:    return "fill";
            4'd5:    return "contention";
            4'd6:    return "flush";
            default: return "unknown";
        endcase
    endfunction

    function automatic src_operand_t make_src(input logic [3:0] ready, input logic [7:0] tag,
                                              input logic [31:0] data);
        src_operand_t src;
        src.ready = ready[0];
        src.tag   = tag_t'(tag);
        src.data  = data;
        return src;
    endfunction

    function automatic logic station_available(input logic [3:0] cmd);
        return (cmd == CMD_ALU) ? alu_rs_available : mul_rs_available;
    endfunction

    // tag now owes exactly one broadcast
    task automatic expect_tag(input tag_t tag, input logic [31:0] value, input logic [3:0] test);
        if (tag_state[tag] != tag_pending) begin
            pending_count++;
        end
        tag_state[tag] = tag_pending;
        exp_data[tag]  = value;
        tag_test[tag]  = test;
    endtask

    task automatic check_cdb(input cdb_t got);
        if ($isunknown(got)) begin
            $display("broadcast with unknown tag or data at %0t", $time);
            protocol_errors++;
        end else begin
            case (tag_state[got.tag])
                tag_pending: begin
                    if (got.data !== exp_data[got.tag]) begin
                        $display("** Error %s: tag %0d expected %h actual %h",
                                 test_name(tag_test[got.tag]), got.tag,
                                 exp_data[got.tag], got.data);
                        value_errors++;
                    end
                    tag_state[got.tag] = tag_done;
                    pending_count--;
                end
                tag_done: begin
                    $display("tag %0d was broadcast a second time", got.tag);
                    protocol_errors++;
                end
                tag_killed: begin
                    $display("tag %0d was broadcast after the flush", got.tag);
                    protocol_errors++;
                end
                default: begin
                    $display("tag %0d was broadcast but never sent in", got.tag);
                    protocol_errors++;
                end
            endcase
        end
    endtask

    task automatic check_available(input logic [3:0] test, input string which,
                                   input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error %s: %s available expected %b actual %b",
                     test_name(test), which, expected, actual);
            value_errors++;
        end
    endtask

    // waits for a free slot and holds valid for one accepting edge
    task automatic dispatch_entry(input vector_t v);
        rs_entry_t entry;
        int        waited;
        entry       = '0;
        entry.valid = 1'b1;
        if (v.cmd == CMD_ALU) begin
            entry.op.alu = alu_op_t'(v.op[2:0]);
        end else begin
            entry.op.mul = mul_op_t'(v.op[2:0]);
        end
        entry.dest = tag_t'(v.dest);
        entry.src1 = make_src(v.ready1, v.tag1, v.data1);
        entry.src2 = make_src(v.ready2, v.tag2, v.data2);
        expect_tag(entry.dest, v.expected, v.test);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!station_available(v.cmd) && waited < WAIT_LIMIT);
        if (!station_available(v.cmd)) begin
            $display("timeout: no free station entry for tag %0d", entry.dest);
            timeouts++;
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            if (v.cmd == CMD_ALU) begin
                alu_dispatch <= entry;
            end else begin
                mul_dispatch <= entry;
            end
            @(posedge clk);
            alu_dispatch.valid <= 1'b0;
            mul_dispatch.valid <= 1'b0;
        end
    endtask

    // load return with the request held until granted
    task automatic return_load(input vector_t v);
        int waited;
        expect_tag(tag_t'(v.dest), v.expected, v.test);
        @(posedge clk);
        ext_req <= '{valid: 1'b1, tag: tag_t'(v.dest), data: v.data1};
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ext_grant && waited < WAIT_LIMIT);
        if (!ext_grant) begin
            $display("timeout: load return for tag %0d never granted", v.dest);
            timeouts++;
            timed_out = 1'b1;
        end
        @(posedge clk);
        ext_req.valid <= 1'b0;
    endtask

    task automatic flush_cluster();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        // last registered broadcast already seen and the rest is gone
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (tag_state[i] == tag_pending) begin
                tag_state[i] = tag_killed;
                pending_count--;
            end
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (pending_count > 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (pending_count > 0) begin
            $display("timeout: %0d results never reached the bus", pending_count);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_command(input vector_t v);
        case (v.cmd)
            CMD_ALU, CMD_MUL: dispatch_entry(v);
            CMD_LOAD:         return_load(v);
            CMD_FLUSH:        flush_cluster();
            CMD_DRAIN:        drain_results();
            CMD_AVAIL: begin
                @(negedge clk);
                check_available(v.test, "alu", v.ready1[0], alu_rs_available);
                check_available(v.test, "mul", v.ready2[0], mul_rs_available);
            end
            // fixed gap that lines a dispatch up with a known alu broadcast
            CMD_IDLE:         repeat (v.op) @(posedge clk);
            default: begin
                $display("unknown command %h in the vector file", v.cmd);
                protocol_errors++;
            end
        endcase
    endtask

    // every broadcast goes through the scoreboard
    always @(negedge clk) begin
        if (rst_n && cdb.valid) begin
            check_cdb(cdb);
        end
    end

    initial begin
        vector_t v;
        logic    done;
        rst_n           = 1'b0;
        flush           = 1'b0;
        alu_dispatch    = '0;
        mul_dispatch    = '0;
        ext_req         = '0;
        pending_count   = 0;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        timed_out       = 1'b0;
        done            = 1'b0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            tag_state[i] = tag_idle;
            exp_data[i]  = '0;
            tag_test[i]  = '0;
        end
        for (int i = 0; i < MAX_VECS; i++) begin
            vector_mem[i] = '0;
        end
        $readmemh("verification/issue_cluster_vectors.txt", vector_mem);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < MAX_VECS && !done; i++) begin
            v = vector_mem[i];
            if (v.cmd == CMD_END || timed_out) begin
                done = 1'b1;
            end else begin
                run_command(v);
            end
        end

        for (int i = 0; i < NUM_TAGS; i++) begin
            if (tag_state[i] == tag_pending) begin
                $display("tag %0d never appeared on the bus", i);
                protocol_errors++;
            end
        end

        $display("errors: %0d wrong values, %0d protocol, %0d timeouts",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
logic/issue_types_pkg.sv
logic/cdb_pkg.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/issue_cluster.sv
verification/issue_cluster_tb.sv

// ==== verification/issue_cluster_vectors.txt ====
// test_cmd_op_dest_ready1_tag1_data1_ready2_tag2_data2_expected, all hex
// cmd 1 alu, 2 mul, 3 load return (dest, data1), 4 flush, 5 drain, 6 avail, 7 idle (op)
1_6_0_00_1_00_00000000_1_00_00000000_00000000
1_1_0_01_1_00_00000005_1_00_00000003_00000008
1_1_5_02_1_00_FFFFFFFB_1_00_FFFFFFFE_00000001
1_1_5_03_1_00_00000003_1_00_FFFFFFFF_00000000
1_1_1_04_1_00_0000000A_1_00_00000014_FFFFFFF6
1_2_0_05_1_00_00001234_1_00_00000010_00012340
1_2_1_06_1_00_80000000_1_00_80000000_40000000
1_2_2_07_1_00_FFFFFFFF_1_00_FFFFFFFF_FFFFFFFF
1_1_4_08_1_00_F0F0F0F0_1_00_0FF00FF0_FF00FF00
1_5_0_00_0_00_00000000_0_00_00000000_00000000
2_2_0_0B_1_00_00000007_1_00_00000006_0000002A
2_1_0_0C_0_0B_00000000_1_00_00000008_00000032
2_1_1_0D_0_0C_00000000_1_00_00000002_00000030
2_2_1_0E_0_0F_00000000_1_00_00000008_00000002
2_3_0_0F_0_00_40000000_0_00_00000000_40000000
2_5_0_00_0_00_00000000_0_00_00000000_00000000
3_1_0_10_1_00_00000100_1_00_00000023_00000123
3_7_1_00_0_00_00000000_0_00_00000000_00000000
3_2_0_11_0_10_00000000_1_00_00000002_00000246
3_5_0_00_0_00_00000000_0_00_00000000_00000000
3_1_3_12_1_00_0000F000_1_00_0000000F_0000F00F
3_1_0_13_0_12_00000000_1_00_00000001_0000F010
3_5_0_00_0_00_00000000_0_00_00000000_00000000
4_1_0_15_0_14_00000000_1_00_00000001_00000011
4_1_1_16_0_14_00000000_1_00_00000004_0000000C
4_1_4_17_1_00_000000FF_0_14_00000000_000000EF
4_1_5_18_0_14_00000000_1_00_00000020_00000001
4_6_0_00_0_00_00000000_1_00_00000000_00000000
4_3_0_14_0_00_00000010_0_00_00000000_00000010
4_5_0_00_0_00_00000000_0_00_00000000_00000000
4_6_0_00_1_00_00000000_1_00_00000000_00000000
5_2_0_19_1_00_00000003_1_00_00000005_0000000F
5_1_0_1A_1_00_00000001_1_00_00000001_00000002
5_2_1_1B_1_00_7FFFFFFF_1_00_7FFFFFFF_3FFFFFFF
5_1_2_1C_1_00_FFFF0000_1_00_0F0F0F0F_0F0F0000
5_3_0_1D_0_00_DEADBEEF_0_00_00000000_DEADBEEF
5_5_0_00_0_00_00000000_0_00_00000000_00000000
6_1_0_1E_0_1F_00000000_1_00_00000001_00000000
6_2_0_00_1_00_00000002_1_00_00000003_00000006
6_1_0_01_1_00_00000004_1_00_00000005_00000009
6_4_0_00_0_00_00000000_0_00_00000000_00000000
6_1_1_02_1_00_00000009_1_00_00000004_00000005
6_2_0_03_1_00_00000009_1_00_00000009_00000051
6_5_0_00_0_00_00000000_0_00_00000000_00000000
6_3_0_1F_0_00_00000077_0_00_00000000_00000077
6_5_0_00_0_00_00000000_0_00_00000000_00000000
